/* hdl/riscv_core_macros.svh */
`ifndef RISCV_CORE_MACROS_SVH
`define RISCV_CORE_MACROS_SVH

`define RV_XLEN     64
`define RV_RESET_PC 64'h8000_0000
`define RV_IQ_DEPTH 4

`endif

/* hdl/riscv_core_isa_pkg.sv */
`default_nettype none

package riscv_core_isa_pkg;

   localparam int ILEN = 32;  // Base instruction width

   // Major opcodes of the base ISA and the supported extensions
   typedef enum logic [6:0] {
      ZERO      = 7'b0000000,  // All-zero word, accepted as legal
      LOAD      = 7'b0000011,
      OP_IMM    = 7'b0010011,
      AUIPC     = 7'b0010111,
      OP_IMM_32 = 7'b0011011,
      STORE     = 7'b0100011,
      AMO       = 7'b0101111,
      OP        = 7'b0110011,
      LUI       = 7'b0110111,
      OP_32     = 7'b0111011,
      BRANCH    = 7'b1100011,
      JALR      = 7'b1100111,
      JAL       = 7'b1101111,
      SYSTEM    = 7'b1110011   // CSR access
   } opcode_e;

   ////////////////////////////////////////////////////////////
   // Instruction field positions and widths
   ////////////////////////////////////////////////////////////
   localparam int OPCODE_LSB = 0;
   localparam int OPCODE_W   = 7;
   localparam int RD_LSB     = 7;
   localparam int FUNCT3_LSB = 12;
   localparam int FUNCT3_W   = 3;
   localparam int RS1_LSB    = 15;
   localparam int RS2_LSB    = 20;
   localparam int FUNCT7_LSB = 25;
   localparam int FUNCT7_W   = 7;
   localparam int FUNCT5_W   = 5;   // Upper bits of funct7 in AMO words
   localparam int REG_W      = 5;   // Register index width

endpackage

`default_nettype wire

/* hdl/riscv_core_ctrl_pkg.sv */
`default_nettype none

package riscv_core_ctrl_pkg;

   typedef enum logic [2:0] {
      IMM_I   = 3'b000,
      IMM_S   = 3'b001,
      IMM_B   = 3'b010,
      IMM_J   = 3'b011,
      IMM_U   = 3'b100,
      IMM_AMO = 3'b101,  // Zero offset for atomics
      IMM_CSR = 3'b110   // Zero-extended uimm field
   } imm_src_e;

   typedef enum logic [1:0] {
      RES_ALU = 2'b00,
      RES_MEM = 2'b01,
      RES_PC4 = 2'b10,  // Link address
      RES_CSR = 2'b11
   } result_src_e;

   typedef enum logic [1:0] {
      SIZE_BYTE   = 2'b00,
      SIZE_HALF   = 2'b01,
      SIZE_WORD   = 2'b10,
      SIZE_DOUBLE = 2'b11
   } mem_size_e;

   // Atomic operation codes as seen by the memory stage
   typedef enum logic [3:0] {
      AMO_SWAP = 4'd0,
      AMO_ADD  = 4'd1,
      AMO_AND  = 4'd2,
      AMO_OR   = 4'd3,
      AMO_XOR  = 4'd4,
      AMO_MAX  = 4'd5,
      AMO_MIN  = 4'd6,
      AMO_MAXU = 4'd7,
      AMO_MINU = 4'd8
   } amo_op_e;

   typedef enum logic [1:0] {
      CSR_NONE = 2'b00,
      CSR_RW   = 2'b01,
      CSR_RS   = 2'b10,
      CSR_RC   = 2'b11
   } csr_op_e;

endpackage

`default_nettype wire

/* hdl/riscv_core_main_decoder.sv */
`default_nettype none

module riscv_core_main_decoder
   import riscv_core_isa_pkg::*;
   import riscv_core_ctrl_pkg::*;
(
   input  logic [OPCODE_W-1:0] i_main_decoder_opcode,
   input  logic [FUNCT3_W-1:0] i_main_decoder_funct3,
   input  logic [FUNCT7_W-1:0] i_main_decoder_funct7,
   output imm_src_e            o_main_decoder_imsrc,
   output logic                o_main_decoder_uctrl,
   output result_src_e         o_main_decoder_resultsrc,
   output logic                o_main_decoder_regwrite,
   output logic                o_main_decoder_alusrcb,
   output logic                o_main_decoder_memwrite,
   output logic                o_main_decoder_branch,
   output logic                o_main_decoder_jump,
   output logic                o_main_decoder_bjreg,
   output mem_size_e           o_main_decoder_size,
   output logic                o_main_decoder_ldext,
   output logic                o_main_decoder_isword,
   output logic                o_main_decoder_aluop,
   output logic                o_main_decoder_imsel,
   output logic                o_main_decoder_new_mux_sel,
   output logic                o_main_decoder_amo,
   output amo_op_e             o_main_decoder_amo_op,
   output logic                o_main_decoder_lr,
   output logic                o_main_decoder_sc,
   output logic                o_main_decoder_src_sel,
   output csr_op_e             o_main_decoder_op,
   output logic                o_main_decoder_illegal,
   output logic                o_main_decoder_read
);

   logic [FUNCT5_W-1:0] funct5;
   opcode_e             opcode;

   assign funct5 = i_main_decoder_funct7[FUNCT7_W-1 -: FUNCT5_W];
   assign opcode = opcode_e'(i_main_decoder_opcode);

   always_comb begin : main_ctrl_proc
      o_main_decoder_regwrite    = 1'b0;
      o_main_decoder_imsrc       = IMM_I;
      o_main_decoder_uctrl       = 1'b0;
      o_main_decoder_alusrcb     = 1'b0;
      o_main_decoder_memwrite    = 1'b0;
      o_main_decoder_resultsrc   = RES_ALU;
      o_main_decoder_branch      = 1'b0;
      o_main_decoder_aluop       = 1'b0;
      o_main_decoder_size        = SIZE_BYTE;
      o_main_decoder_ldext       = 1'b0;
      o_main_decoder_isword      = 1'b0;
      o_main_decoder_jump        = 1'b0;
      o_main_decoder_bjreg       = 1'b0;
      o_main_decoder_imsel       = 1'b0;
      o_main_decoder_new_mux_sel = 1'b0;
      o_main_decoder_amo         = 1'b0;
      o_main_decoder_amo_op      = AMO_SWAP;
      o_main_decoder_lr          = 1'b0;
      o_main_decoder_sc          = 1'b0;
      o_main_decoder_src_sel     = 1'b0;
      o_main_decoder_op          = CSR_NONE;
      o_main_decoder_read        = 1'b0;
      o_main_decoder_illegal     = 1'b0;

      case (opcode)
         ZERO: ;
         ////////////////////////////////////////////////////////////
         // Integer register and immediate ops
         ////////////////////////////////////////////////////////////
         OP, OP_32: begin
            o_main_decoder_regwrite = 1'b1;
            o_main_decoder_aluop    = 1'b1;
            o_main_decoder_isword   = (opcode == OP_32);
            o_main_decoder_imsel    = i_main_decoder_funct7[0];  // M extension
         end
         OP_IMM, OP_IMM_32: begin
            o_main_decoder_regwrite = 1'b1;
            o_main_decoder_alusrcb  = 1'b1;
            o_main_decoder_aluop    = 1'b1;
            o_main_decoder_isword   = (opcode == OP_IMM_32);
         end
         ////////////////////////////////////////////////////////////
         // Memory access
         ////////////////////////////////////////////////////////////
         LOAD: begin
            o_main_decoder_regwrite  = 1'b1;
            o_main_decoder_alusrcb   = 1'b1;
            o_main_decoder_resultsrc = RES_MEM;
            o_main_decoder_read      = 1'b1;
            if (i_main_decoder_funct3 != 3'h7) begin  // 3'h7 is not a load
               o_main_decoder_size  = mem_size_e'(i_main_decoder_funct3[1:0]);
               o_main_decoder_ldext = i_main_decoder_funct3[2];  // Unsigned loads
            end
         end
         STORE: begin
            o_main_decoder_imsrc    = IMM_S;
            o_main_decoder_alusrcb  = 1'b1;
            o_main_decoder_memwrite = 1'b1;
            if (!i_main_decoder_funct3[2]) begin
               o_main_decoder_size = mem_size_e'(i_main_decoder_funct3[1:0]);
            end
         end
         AMO: begin
            o_main_decoder_regwrite  = 1'b1;
            o_main_decoder_imsrc     = IMM_AMO;
            o_main_decoder_alusrcb   = 1'b1;
            o_main_decoder_memwrite  = 1'b1;
            o_main_decoder_resultsrc = RES_MEM;
            o_main_decoder_size      = i_main_decoder_funct3[0] ? SIZE_DOUBLE : SIZE_WORD;
            o_main_decoder_ldext     = (funct5[4:3] == 2'b11);  // Unsigned min and max
            o_main_decoder_read      = (funct5 != 5'b00011);    // SC does not read
            // Every xxx00 code is a read-modify-write op, as is swap
            o_main_decoder_amo       = (funct5[1:0] == 2'b00) || (funct5 == 5'b00001);
            case (funct5)
               5'b00010: o_main_decoder_lr     = 1'b1;
               5'b00011: o_main_decoder_sc     = 1'b1;
               5'b00000: o_main_decoder_amo_op = AMO_ADD;
               5'b01100: o_main_decoder_amo_op = AMO_AND;
               5'b01000: o_main_decoder_amo_op = AMO_OR;
               5'b00100: o_main_decoder_amo_op = AMO_XOR;
               5'b10100: o_main_decoder_amo_op = AMO_MAX;
               5'b10000: o_main_decoder_amo_op = AMO_MIN;
               5'b11100: o_main_decoder_amo_op = AMO_MAXU;
               5'b11000: o_main_decoder_amo_op = AMO_MINU;
               default:  o_main_decoder_amo_op = AMO_SWAP;
            endcase
         end
         ////////////////////////////////////////////////////////////
         // Control flow and upper immediates
         ////////////////////////////////////////////////////////////
         BRANCH: begin
            o_main_decoder_imsrc       = IMM_B;
            o_main_decoder_alusrcb     = 1'b1;
            o_main_decoder_branch      = 1'b1;
            o_main_decoder_new_mux_sel = 1'b1;
         end
         JAL, JALR: begin
            o_main_decoder_regwrite    = 1'b1;
            o_main_decoder_imsrc       = (opcode == JAL) ? IMM_J : IMM_I;
            o_main_decoder_alusrcb     = 1'b1;
            o_main_decoder_resultsrc   = RES_PC4;
            o_main_decoder_jump        = 1'b1;
            o_main_decoder_bjreg       = (opcode == JALR);  // Target from rs1
            o_main_decoder_new_mux_sel = 1'b1;
         end
         LUI, AUIPC: begin
            o_main_decoder_regwrite    = 1'b1;
            o_main_decoder_imsrc       = IMM_U;
            o_main_decoder_uctrl       = (opcode == LUI);
            o_main_decoder_alusrcb     = 1'b1;
            o_main_decoder_new_mux_sel = 1'b1;
            o_main_decoder_read        = (opcode == LUI);
         end
         SYSTEM: begin
            o_main_decoder_regwrite  = 1'b1;
            o_main_decoder_imsrc     = IMM_CSR;
            o_main_decoder_resultsrc = RES_CSR;
            o_main_decoder_src_sel   = i_main_decoder_funct3[2];  // Immediate form
            o_main_decoder_op        = csr_op_e'(i_main_decoder_funct3[1:0]);
         end
         default: o_main_decoder_illegal = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

/* hdl/riscv_core_pc_tagger.sv */
`default_nettype none

`include "riscv_core_macros.svh"

module riscv_core_pc_tagger
   import riscv_core_isa_pkg::*;
(
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_instr_valid,
   input  logic [ILEN-1:0]     i_instr,
   input  logic                i_redirect,
   input  logic [`RV_XLEN-1:0] i_redirect_pc,
   output logic                o_push,
   output logic [`RV_XLEN-1:0] o_pc,
   output logic [ILEN-1:0]     o_instr,
   output logic                o_flush
);

   logic [`RV_XLEN-1:0] fetch_pc;

   // Flush acts on the redirect edge so the in-flight push is dropped too
   assign o_flush = i_redirect;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         fetch_pc <= `RV_RESET_PC;
         o_push   <= 1'b0;
      end else if (i_redirect) begin
         fetch_pc <= i_redirect_pc;
         o_push   <= 1'b0;  // Cancel same-cycle strobe
      end else begin
         o_push <= i_instr_valid;
         if (i_instr_valid) begin
            fetch_pc <= fetch_pc + `RV_XLEN'(4);
         end
      end
   end

   // Word and its address
   always_ff @(posedge i_clk) begin
      if (i_instr_valid) begin
         o_pc    <= fetch_pc;
         o_instr <= i_instr;
      end
   end

endmodule

`default_nettype wire

/* hdl/riscv_core_instr_queue.sv */
`default_nettype none

`include "riscv_core_macros.svh"

module riscv_core_instr_queue
   import riscv_core_isa_pkg::*;
(
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_push,
   input  logic [`RV_XLEN-1:0] i_pc,
   input  logic [ILEN-1:0]     i_instr,
   input  logic                i_pop,
   input  logic                i_flush,
   output logic [`RV_XLEN-1:0] o_head_pc,
   output logic [ILEN-1:0]     o_head_instr,
   output logic                o_empty,
   output logic                o_full
);

   localparam int DEPTH = `RV_IQ_DEPTH;  // Power of two, pointers wrap freely
   localparam int PTR_W = $clog2(DEPTH);

   logic [`RV_XLEN-1:0] pc_mem    [DEPTH];
   logic [ILEN-1:0]     instr_mem [DEPTH];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   logic [PTR_W:0]      count;

   assign o_head_pc    = pc_mem[rd_ptr];     // Show-ahead head
   assign o_head_instr = instr_mem[rd_ptr];
   assign o_empty      = (count == '0);

   // The push already on its way counts as taken, so a source that
   // watches this flag never overruns the last slot
   assign o_full = (count == (PTR_W + 1)'(DEPTH)) ||
                   (i_push && (count == (PTR_W + 1)'(DEPTH - 1)));

   always_ff @(posedge i_clk) begin
      if (i_rst || i_flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (i_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({i_push, i_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Idle or push with pop
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_push) begin
         pc_mem[wr_ptr]    <= i_pc;
         instr_mem[wr_ptr] <= i_instr;
      end
   end

endmodule

`default_nettype wire

/* hdl/riscv_core_decode_stage.sv */
`default_nettype none

`include "riscv_core_macros.svh"

module riscv_core_decode_stage
   import riscv_core_isa_pkg::*;
   import riscv_core_ctrl_pkg::*;
(
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic [`RV_XLEN-1:0] i_head_pc,
   input  logic [ILEN-1:0]     i_head_instr,
   input  logic                i_empty,
   input  logic                i_stall,
   input  logic                i_flush,
   output logic                o_pop,
   output logic                o_dec_valid,
   output logic [`RV_XLEN-1:0] o_dec_pc,
   output logic [REG_W-1:0]    o_dec_rd,
   output logic [REG_W-1:0]    o_dec_rs1,
   output logic [REG_W-1:0]    o_dec_rs2,
   output logic                o_dec_regwrite,
   output imm_src_e            o_dec_imsrc,
   output logic                o_dec_uctrl,
   output result_src_e         o_dec_resultsrc,
   output logic                o_dec_alusrcb,
   output logic                o_dec_memwrite,
   output logic                o_dec_branch,
   output logic                o_dec_jump,
   output logic                o_dec_bjreg,
   output mem_size_e           o_dec_size,
   output logic                o_dec_ldext,
   output logic                o_dec_isword,
   output logic                o_dec_aluop,
   output logic                o_dec_imsel,
   output logic                o_dec_new_mux_sel,
   output logic                o_dec_amo,
   output amo_op_e             o_dec_amo_op,
   output logic                o_dec_lr,
   output logic                o_dec_sc,
   output logic                o_dec_src_sel,
   output csr_op_e             o_dec_op,
   output logic                o_dec_illegal,
   output logic                o_dec_read
);

   imm_src_e    md_imsrc;
   result_src_e md_resultsrc;
   mem_size_e   md_size;
   amo_op_e     md_amo_op;
   csr_op_e     md_op;
   logic        md_regwrite, md_uctrl, md_alusrcb, md_memwrite, md_branch, md_jump;
   logic        md_bjreg, md_ldext, md_isword, md_aluop, md_imsel, md_new_mux_sel;
   logic        md_amo, md_lr, md_sc, md_src_sel, md_illegal, md_read;

   assign o_pop = !i_empty && !i_stall;  // Queue trusts this

   riscv_core_main_decoder u_main_decoder (
      .i_main_decoder_opcode      (i_head_instr[OPCODE_LSB +: OPCODE_W]),
      .i_main_decoder_funct3      (i_head_instr[FUNCT3_LSB +: FUNCT3_W]),
      .i_main_decoder_funct7      (i_head_instr[FUNCT7_LSB +: FUNCT7_W]),
      .o_main_decoder_imsrc       (md_imsrc),
      .o_main_decoder_uctrl       (md_uctrl),
      .o_main_decoder_resultsrc   (md_resultsrc),
      .o_main_decoder_regwrite    (md_regwrite),
      .o_main_decoder_alusrcb     (md_alusrcb),
      .o_main_decoder_memwrite    (md_memwrite),
      .o_main_decoder_branch      (md_branch),
      .o_main_decoder_jump        (md_jump),
      .o_main_decoder_bjreg       (md_bjreg),
      .o_main_decoder_size        (md_size),
      .o_main_decoder_ldext       (md_ldext),
      .o_main_decoder_isword      (md_isword),
      .o_main_decoder_aluop       (md_aluop),
      .o_main_decoder_imsel       (md_imsel),
      .o_main_decoder_new_mux_sel (md_new_mux_sel),
      .o_main_decoder_amo         (md_amo),
      .o_main_decoder_amo_op      (md_amo_op),
      .o_main_decoder_lr          (md_lr),
      .o_main_decoder_sc          (md_sc),
      .o_main_decoder_src_sel     (md_src_sel),
      .o_main_decoder_op          (md_op),
      .o_main_decoder_illegal     (md_illegal),
      .o_main_decoder_read        (md_read)
   );

   always_ff @(posedge i_clk) begin
      if (i_rst || i_flush) begin
         o_dec_valid <= 1'b0;
      end else begin
         o_dec_valid <= o_pop;  // One pulse per popped word
      end
   end

   // Results held until the next pop
   always_ff @(posedge i_clk) begin
      if (o_pop) begin
         o_dec_pc          <= i_head_pc;
         o_dec_rd          <= i_head_instr[RD_LSB +: REG_W];
         o_dec_rs1         <= i_head_instr[RS1_LSB +: REG_W];
         o_dec_rs2         <= i_head_instr[RS2_LSB +: REG_W];
         o_dec_regwrite    <= md_regwrite;
         o_dec_imsrc       <= md_imsrc;
         o_dec_uctrl       <= md_uctrl;
         o_dec_resultsrc   <= md_resultsrc;
         o_dec_alusrcb     <= md_alusrcb;
         o_dec_memwrite    <= md_memwrite;
         o_dec_branch      <= md_branch;
         o_dec_jump        <= md_jump;
         o_dec_bjreg       <= md_bjreg;
         o_dec_size        <= md_size;
         o_dec_ldext       <= md_ldext;
         o_dec_isword      <= md_isword;
         o_dec_aluop       <= md_aluop;
         o_dec_imsel       <= md_imsel;
         o_dec_new_mux_sel <= md_new_mux_sel;
         o_dec_amo         <= md_amo;
         o_dec_amo_op      <= md_amo_op;
         o_dec_lr          <= md_lr;
         o_dec_sc          <= md_sc;
         o_dec_src_sel     <= md_src_sel;
         o_dec_op          <= md_op;
         o_dec_illegal     <= md_illegal;
         o_dec_read        <= md_read;
      end
   end

endmodule

`default_nettype wire

/* hdl/riscv_core_frontend.sv */
`default_nettype none

`include "riscv_core_macros.svh"

module riscv_core_frontend
   import riscv_core_isa_pkg::*;
   import riscv_core_ctrl_pkg::*;
(
   input  logic                i_clk,
   input  logic                i_rst,
   input  logic                i_instr_valid,
   input  logic [ILEN-1:0]     i_instr,
   input  logic                i_redirect,
   input  logic [`RV_XLEN-1:0] i_redirect_pc,
   input  logic                i_stall,
   output logic                o_iq_full,
   output logic                o_dec_valid,
   output logic [`RV_XLEN-1:0] o_dec_pc,
   output logic [REG_W-1:0]    o_dec_rd,
   output logic [REG_W-1:0]    o_dec_rs1,
   output logic [REG_W-1:0]    o_dec_rs2,
   output logic                o_dec_regwrite,
   output imm_src_e            o_dec_imsrc,
   output logic                o_dec_uctrl,
   output result_src_e         o_dec_resultsrc,
   output logic                o_dec_alusrcb,
   output logic                o_dec_memwrite,
   output logic                o_dec_branch,
   output logic                o_dec_jump,
   output logic                o_dec_bjreg,
   output mem_size_e           o_dec_size,
   output logic                o_dec_ldext,
   output logic                o_dec_isword,
   output logic                o_dec_aluop,
   output logic                o_dec_imsel,
   output logic                o_dec_new_mux_sel,
   output logic                o_dec_amo,
   output amo_op_e             o_dec_amo_op,
   output logic                o_dec_lr,
   output logic                o_dec_sc,
   output logic                o_dec_src_sel,
   output csr_op_e             o_dec_op,
   output logic                o_dec_illegal,
   output logic                o_dec_read
);

   logic                push;
   logic [`RV_XLEN-1:0] tag_pc;
   logic [ILEN-1:0]     tag_instr;
   logic                flush;
   logic [`RV_XLEN-1:0] head_pc;
   logic [ILEN-1:0]     head_instr;
   logic                empty;
   logic                pop;

   riscv_core_pc_tagger u_tagger (
      .i_clk,
      .i_rst,
      .i_instr_valid,
      .i_instr,
      .i_redirect,
      .i_redirect_pc,
      .o_push  (push),
      .o_pc    (tag_pc),
      .o_instr (tag_instr),
      .o_flush (flush)
   );

   riscv_core_instr_queue u_queue (
      .i_clk,
      .i_rst,
      .i_push       (push),
      .i_pc         (tag_pc),
      .i_instr      (tag_instr),
      .i_pop        (pop),
      .i_flush      (flush),
      .o_head_pc    (head_pc),
      .o_head_instr (head_instr),
      .o_empty      (empty),
      .o_full       (o_iq_full)
   );

   // Decoded outputs go straight to the top-level ports of the same name
   riscv_core_decode_stage u_decode (
      .i_clk,
      .i_rst,
      .i_head_pc    (head_pc),
      .i_head_instr (head_instr),
      .i_empty      (empty),
      .i_stall,
      .i_flush      (flush),
      .o_pop        (pop),
      .*
   );

endmodule

`default_nettype wire

/* tb/riscv_core_frontend_checker.sv */
`default_nettype none

module riscv_core_frontend_checker (
   input wire logic i_clk,
   input wire logic i_rst,
   input wire logic i_instr_valid,
   input wire logic i_redirect,
   input wire logic i_stall,
   input wire logic o_iq_full,
   input wire logic o_dec_valid
);

   timeunit 1ns;
   timeprecision 1ps;

   // Source has no handshake, it must watch the full level
   a_no_strobe_when_full : assert property (
      @(posedge i_clk) disable iff (i_rst) i_instr_valid |-> !o_iq_full
   ) else $error("instruction strobed while the queue reports full");

   a_no_valid_after_stall : assert property (
      @(posedge i_clk) disable iff (i_rst) (i_stall || i_redirect) |=> !o_dec_valid
   ) else $error("decode valid seen one cycle after a stall or redirect");

   a_quiet_after_reset : assert property (
      @(posedge i_clk) i_rst |=> (!o_iq_full && !o_dec_valid)
   ) else $error("full or decode valid high in the cycle after reset");

endmodule

bind riscv_core_frontend riscv_core_frontend_checker u_checker (
   .i_clk         (i_clk),
   .i_rst         (i_rst),
   .i_instr_valid (i_instr_valid),
   .i_redirect    (i_redirect),
   .i_stall       (i_stall),
   .o_iq_full     (o_iq_full),
   .o_dec_valid   (o_dec_valid)
);

`default_nettype wire

/* tb/riscv_core_frontend_tb.sv */
`default_nettype none

`include "riscv_core_macros.svh"

module riscv_core_frontend_tb
   import riscv_core_isa_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_LINES    = 37;
   localparam int TIMEOUT    = 20 * N_LINES + 50;  // In clock cycles
   localparam int STALL_FROM = 30;  // Held stall so the queue fills
   localparam int STALL_TO   = 44;

   typedef struct {
      logic [63:0] pc;
      logic [31:0] instr;
      logic [31:0] ctrl;
      int          cycle;  // Edge at which the word was strobed
      bit          idle;   // Pipeline empty and never stalled
   } exp_t;

   logic i_clk, i_rst, i_instr_valid, i_redirect, i_stall;
   logic [ILEN-1:0] i_instr;
   logic [`RV_XLEN-1:0] i_redirect_pc;
   logic o_iq_full, o_dec_valid;
   logic [`RV_XLEN-1:0] o_dec_pc;
   logic [REG_W-1:0] o_dec_rd, o_dec_rs1, o_dec_rs2;
   logic o_dec_regwrite, o_dec_uctrl, o_dec_alusrcb, o_dec_memwrite, o_dec_branch;
   logic o_dec_jump, o_dec_bjreg, o_dec_ldext, o_dec_isword, o_dec_aluop, o_dec_imsel;
   logic o_dec_new_mux_sel, o_dec_amo, o_dec_lr, o_dec_sc, o_dec_src_sel;
   logic o_dec_illegal, o_dec_read;
   logic [2:0] o_dec_imsrc;
   logic [1:0] o_dec_resultsrc, o_dec_size, o_dec_op;
   logic [3:0] o_dec_amo_op;

   logic [63:0] stim [4*N_LINES];  // instr, ctrl, redirect flag, target
   logic [31:0] got_ctrl;
   logic [31:0] lcg_state = 32'hcbb47905;
   logic [63:0] exp_pc = `RV_RESET_PC;
   exp_t        exp_q [$];
   exp_t        e_new;
   int          cycle = 0;
   int          line_idx = 0;
   int          drain = 0;
   int          unconsumed = 0;
   bit          strobed_last = 1'b0;
   bit          redirect_done = 1'b0;
   bit          flush_pending = 1'b0;
   bit          stall_next = 1'b0;
   bit          full_seen = 1'b0;
   bit          latency_seen = 1'b0;

   riscv_core_frontend UUT (.*);

   // Nibble-aligned control layout, same as the data file
   assign got_ctrl = {o_dec_regwrite, o_dec_alusrcb, o_dec_memwrite, o_dec_read,
                      o_dec_branch, o_dec_jump, o_dec_bjreg, o_dec_new_mux_sel,
                      o_dec_uctrl, o_dec_isword, o_dec_aluop, o_dec_imsel,
                      1'b0, o_dec_imsrc, o_dec_resultsrc, o_dec_size,
                      o_dec_ldext, o_dec_amo, o_dec_lr, o_dec_sc,
                      o_dec_amo_op, o_dec_illegal, o_dec_src_sel, o_dec_op};

   initial begin
      i_clk = 1'b0;
      forever #5 i_clk = ~i_clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         $display("FAIL @%0t: %s is %0h, expected %0h", $time, what, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "decode output mismatch");
      end
   endtask

   task automatic check_output();
      exp_t e;
      assert (exp_q.size() != 0) else begin
         $display("A decoded word came out with nothing outstanding at %0t", $time);
         $display("STATUS: FAIL");
         $fatal(1, "extra decode output");
      end
      e = exp_q.pop_front();
      check_value("pc", o_dec_pc, e.pc);
      check_value("rd", 64'(o_dec_rd), 64'(e.instr[11:7]));
      check_value("rs1", 64'(o_dec_rs1), 64'(e.instr[19:15]));
      check_value("rs2", 64'(o_dec_rs2), 64'(e.instr[24:20]));
      check_value("ctrl", 64'(got_ctrl), 64'(e.ctrl));
      if (e.idle) begin
         check_value("latency", 64'(cycle - e.cycle), 64'd4);  // Strobe edge to sample edge
         latency_seen = 1'b1;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus and scoreboard, one pass per rising edge
   ////////////////////////////////////////////////////////////
   initial begin
      i_rst         = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      i_redirect    = 1'b0;
      i_redirect_pc = '0;
      i_stall       = 1'b0;
      $readmemh("tb/riscv_core_frontend_input.txt", stim);
      repeat (3) @(posedge i_clk);
      i_rst <= 1'b0;
      while (line_idx < N_LINES || exp_q.size() != 0 || drain < 5) begin
         @(posedge i_clk);
         cycle++;
         if (cycle >= TIMEOUT) begin
            $display("Timeout after %0d cycles with %0d words outstanding", cycle,
                     exp_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
         end
         if (o_dec_valid) begin
            check_output();
         end
         // Words tagged and not yet popped, the newest strobe is not sampled yet
         unconsumed = exp_q.size();
         if (unconsumed != 0 && exp_q[$].cycle == cycle - 1) begin
            unconsumed--;
         end
         check_value("iq_full", 64'(o_iq_full), 64'(unconsumed >= `RV_IQ_DEPTH));
         if (o_iq_full) begin
            full_seen = 1'b1;
         end
         if (flush_pending) begin  // Outputs in the redirect cycle were still live
            exp_q.delete();
            flush_pending = 1'b0;
         end
         lcg_state = lcg_next(lcg_state);
         stall_next = (cycle >= 4) &&  // First word sees an idle pipeline
                      ((lcg_state[31:16] % 16'd3 == 16'd0) ||
                       (cycle >= STALL_FROM && cycle <= STALL_TO));
         i_stall <= stall_next;
         if (exp_q.size() != 0 && cycle == exp_q[0].cycle + 2 && stall_next) begin
            exp_q[0].idle = 1'b0;  // Pop cycle stalled
         end
         i_redirect    <= 1'b0;
         i_instr_valid <= 1'b0;
         if (line_idx < N_LINES && !o_iq_full && !strobed_last) begin
            i_instr_valid <= 1'b1;
            i_instr       <= stim[4*line_idx][31:0];
            strobed_last = 1'b1;
            if (stim[4*line_idx+2][0] && !redirect_done) begin
               i_redirect    <= 1'b1;  // Same-cycle strobe must be dropped
               i_redirect_pc <= stim[4*line_idx+3];
               exp_pc        = stim[4*line_idx+3];
               flush_pending = 1'b1;
               redirect_done = 1'b1;
            end else begin
               e_new.pc    = exp_pc;
               e_new.instr = stim[4*line_idx][31:0];
               e_new.ctrl  = stim[4*line_idx+1][31:0];
               e_new.cycle = cycle;
               e_new.idle  = (exp_q.size() == 0);
               exp_q.push_back(e_new);
               exp_pc        = exp_pc + 64'd4;
               line_idx      = line_idx + 1;
               redirect_done = 1'b0;
            end
         end else begin
            strobed_last = 1'b0;
         end
         if (line_idx == N_LINES && exp_q.size() == 0) begin
            drain++;  // Watch for stray outputs
         end
      end
      if (line_idx == N_LINES && exp_q.size() == 0 && full_seen && latency_seen) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         $display("Run ended with %0d words never decoded, full seen %0b, latency checked %0b",
                  exp_q.size(), full_seen, latency_seen);
         $display("STATUS: FAIL");
         $fatal(1, "incomplete run");
      end
   end

endmodule

`default_nettype wire

/* tb/riscv_core_frontend_input.txt */
// instr    ctrl     redirect  target
// ctrl nibbles: {rw,srcb,mw,rd} {br,j,bjr,mux} {u,w,alu,m} imm {res,size} {ldx,amo,lr,sc} amoop {ill,sel,op}
003100B3 80200000 0 0000000000000000
02D605BB 80700000 0 0000000000000000
12378713 C0200000 0 0000000000000000
FFF8881B C0600000 0 0000000000000000
00810903 D0004000 0 0000000000000000
00811903 D0005000 0 0000000000000000
00812903 D0006000 0 0000000000000000
00813903 D0007000 0 0000000000000000
00814903 D0004800 0 0000000000000000
00815903 D0005800 0 0000000000000000
00816903 D0006800 0 0000000000000000
00510223 60010000 1 0000000000001000
00511223 60011000 0 0000000000000000
00512223 60012000 0 0000000000000000
00513223 60013000 0 0000000000000000
1005A52F F0056200 0 0000000000000000
18C5B52F E0057100 0 0000000000000000
08C5A52F F0056400 0 0000000000000000
00C5B52F F0057410 0 0000000000000000
20C5A52F F0056440 0 0000000000000000
60C5B52F F0057420 0 0000000000000000
40C5A52F F0056430 0 0000000000000000
80C5B52F F0057460 0 0000000000000000
A0C5A52F F0056450 0 0000000000000000
C0C5B52F F0057C80 0 0000000000000000
E0C5A52F F0056C70 0 0000000000000000
00208463 49020000 1 0000000040000100
010000EF C5038000 0 0000000000000000
00008067 C7008000 0 0000000000000000
123452B7 D1840000 0 0000000000000000
00001317 C1040000 0 0000000000000000
300413F3 8006C001 0 0000000000000000
300423F3 8006C002 0 0000000000000000
300433F3 8006C003 0 0000000000000000
300453F3 8006C005 0 0000000000000000
00000000 00000000 0 0000000000000000
FFFFFFFF 00000008 0 0000000000000000

/* riscv_core_frontend.f */
+incdir+hdl
hdl/riscv_core_isa_pkg.sv
hdl/riscv_core_ctrl_pkg.sv
hdl/riscv_core_main_decoder.sv
hdl/riscv_core_pc_tagger.sv
hdl/riscv_core_instr_queue.sv
hdl/riscv_core_decode_stage.sv
hdl/riscv_core_frontend.sv
tb/riscv_core_frontend_checker.sv
tb/riscv_core_frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := riscv_core_frontend_tb
FILELIST  := riscv_core_frontend.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
